// ==== rtl/dcachePkg.sv ====
package dcachePkg;

  // geometry
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned Xlen        = 64;
  localparam int unsigned Ways        = 2;
  localparam int unsigned Sets        = 64;
  localparam int unsigned IndexWidth  = 6;
  localparam int unsigned OffsetWidth = 5;
  localparam int unsigned TagWidth    = 21;
  localparam int unsigned LineWords   = 4;
  localparam int unsigned LineBytes   = 32;

  // top nibble of cacheable space
  localparam logic [3:0] CachedRegion = 4'b1000;

  // burst length codes as beats minus one
  localparam logic [7:0] BurstLenLine = 8'd3;
  localparam logic [7:0] BurstLenWord = 8'd0;

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    COMPARE   = 3'd1,
    WRITEBACK = 3'd2,
    MISS      = 3'd3,
    REFILL    = 3'd4,
    REPLACE   = 3'd5,
    UNCACHED  = 3'd6
  } cacheStateT;

  // word view for beats and reads, byte view for masked stores
  typedef union packed {
    logic [LineWords-1:0][Xlen-1:0] words;
    logic [LineBytes-1:0][7:0]      bytes;
  } lineT;

  typedef struct packed {
    logic [TagWidth-1:0]    tag;
    logic [IndexWidth-1:0]  index;
    logic [OffsetWidth-1:0] offset;
  } cacheAddrT;

endpackage

// ==== rtl/refillBuffer.sv ====
`timescale 1ns/1ps

module refillBuffer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       capture_i,
  input  logic                       beatValid_i,
  input  logic [dcachePkg::Xlen-1:0] beatData_i,
  output dcachePkg::lineT            line_o
);
  import dcachePkg::*;

  logic [$clog2(LineWords)-1:0] beatCnt;

  // wraps to zero after the last beat of a line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (capture_i && beatValid_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (capture_i && beatValid_i) begin
      line_o.words[beatCnt] <= beatData_i;
    end
  end

endmodule

// ==== rtl/lineStore.sv ====
`timescale 1ns/1ps

module lineStore (
  input  logic                         clk,
  input  dcachePkg::cacheAddrT         reqAddr_i,
  input  logic                         lineWrite_i,
  input  logic                         wordWrite_i,
  input  logic                         wrWay_i,
  input  dcachePkg::lineT              refillLine_i,
  input  logic [dcachePkg::Xlen-1:0]   wrData_i,
  input  logic [dcachePkg::Xlen/8-1:0] wrMask_i,
  output dcachePkg::lineT              way0Line_o,
  output dcachePkg::lineT              way1Line_o
);
  import dcachePkg::*;

  lineT                  dataArr [Ways][Sets];
  lineT                  merged;
  logic [IndexWidth-1:0] idx;
  logic [1:0]            wordSel;

  assign idx     = reqAddr_i.index;
  assign wordSel = reqAddr_i.offset[OffsetWidth-1:3];

  // store word merged byte by byte into the current line
  always_comb begin
    merged = wrWay_i ? way1Line_o : way0Line_o;
    for (int b = 0; b < Xlen / 8; b++) begin
      if (wrMask_i[b]) begin
        merged.bytes[wordSel * (Xlen / 8) + b] = wrData_i[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lineWrite_i) begin
      dataArr[wrWay_i][idx] <= refillLine_i;
    end else if (wordWrite_i) begin
      dataArr[wrWay_i][idx] <= merged;
    end
  end

  // both ways read together for compare
  assign way0Line_o = dataArr[0][idx];
  assign way1Line_o = dataArr[1][idx];

endmodule

// ==== rtl/tagStore.sv ====
`timescale 1ns/1ps

module tagStore (
  input  logic                          clk,
  input  logic                          rst_n,
  input  dcachePkg::cacheAddrT          reqAddr_i,
  input  dcachePkg::cacheStateT         state_i,
  input  logic                          wordWrite_i,
  input  logic                          lineWrite_i,
  output logic                          hit_o,
  output logic                          hitWay_o,
  output logic                          victimWay_o,
  output logic                          victimDirty_o,
  output logic [dcachePkg::TagWidth-1:0] victimTag_o
);
  import dcachePkg::*;

  logic [TagWidth-1:0]   tagArr [Ways][Sets];
  logic [Sets-1:0]       validArr [Ways];
  logic [Sets-1:0]       dirtyArr [Ways];
  logic [Ways-1:0]       wayHit;
  logic [IndexWidth-1:0] idx;
  logic                  victimPtr;

  assign idx = reqAddr_i.index;

  always_comb begin
    for (int w = 0; w < Ways; w++) begin
      wayHit[w] = validArr[w][idx] && (tagArr[w][idx] == reqAddr_i.tag);
    end
  end

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  // pointer has already moved on once the miss leaves compare
  assign victimWay_o   = (state_i == COMPARE) ? victimPtr : ~victimPtr;
  assign victimDirty_o = dirtyArr[victimWay_o][idx];
  assign victimTag_o   = tagArr[victimWay_o][idx];

  // toggles once per miss
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimPtr <= 1'b0;
    end else if ((state_i == COMPARE) && !hit_o) begin
      victimPtr <= ~victimPtr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < Ways; w++) begin
        validArr[w] <= '0;
        dirtyArr[w] <= '0;
      end
    end else if (lineWrite_i) begin
      // freshly refilled line is clean
      validArr[victimWay_o][idx] <= 1'b1;
      dirtyArr[victimWay_o][idx] <= 1'b0;
    end else if (wordWrite_i) begin
      dirtyArr[hitWay_o][idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (lineWrite_i) begin
      tagArr[victimWay_o][idx] <= reqAddr_i.tag;
    end
  end

endmodule

// ==== rtl/dcacheCtrl.sv ====
`timescale 1ns/1ps

module dcacheCtrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  reqValid_i,
  input  logic                  reqWrite_i,
  input  dcachePkg::cacheAddrT  reqAddr_i,
  input  logic                  hit_i,
  input  logic                  victimDirty_i,
  input  logic                  memRdReady_i,
  input  logic                  memRdDataValid_i,
  input  logic                  memRdLast_i,
  input  logic                  memWrReady_i,
  output dcachePkg::cacheStateT state_o,
  output dcachePkg::cacheAddrT  reqAddr_o,
  output logic                  reqWrite_o,
  output logic                  addrOk_o,
  output logic                  dataOk_o,
  output logic                  memRdValid_o,
  output logic                  memWrValid_o,
  output logic                  lineWrite_o,
  output logic                  wordWrite_o
);
  import dcachePkg::*;

  cacheStateT state;
  cacheStateT nextState;
  logic       accept;
  logic       uncached;

  assign accept = reqValid_i && addrOk_o;

  // only stores leave the cache, loads always take the cached path
  assign uncached = reqAddr_i.tag[TagWidth-1 -: 4] != CachedRegion;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (accept) begin
          nextState = (reqWrite_i && uncached) ? UNCACHED : COMPARE;
        end
      end
      COMPARE: begin
        if (hit_i) begin
          nextState = IDLE;
        end else begin
          nextState = victimDirty_i ? WRITEBACK : MISS;
        end
      end
      WRITEBACK: begin
        // dirty victim must reach memory before the refill read
        if (memWrReady_i) begin
          nextState = MISS;
        end
      end
      MISS: begin
        if (memRdReady_i) begin
          nextState = REFILL;
        end
      end
      REFILL: begin
        if (memRdDataValid_i && memRdLast_i) begin
          nextState = REPLACE;
        end
      end
      REPLACE: begin
        nextState = COMPARE;
      end
      UNCACHED: begin
        if (memWrReady_i) begin
          nextState = IDLE;
        end
      end
      default: begin
        nextState = IDLE;
      end
    endcase
  end

  // request latch
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr_o <= reqAddr_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqWrite_o <= 1'b0;
    end else if (accept) begin
      reqWrite_o <= reqWrite_i;
    end
  end

  assign state_o      = state;
  assign addrOk_o     = state == IDLE;
  assign memRdValid_o = state == MISS;
  assign memWrValid_o = (state == WRITEBACK) || (state == UNCACHED);
  assign lineWrite_o  = state == REPLACE;
  assign wordWrite_o  = (state == COMPARE) && hit_i && reqWrite_o;

  // hit in compare or uncached write taken by memory
  assign dataOk_o = ((state == COMPARE) && hit_i) ||
                    ((state == UNCACHED) && memWrReady_i);

endmodule

// ==== rtl/dcache.sv ====
`timescale 1ns/1ps

module dcache (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            reqValid_i,
  input  logic                            reqWrite_i,
  input  logic [dcachePkg::AddrWidth-1:0] reqAddr_i,
  input  logic [dcachePkg::Xlen-1:0]      wrData_i,
  input  logic [dcachePkg::Xlen/8-1:0]    wrMask_i,
  output logic                            addrOk_o,
  output logic                            dataOk_o,
  output logic [dcachePkg::Xlen-1:0]      rdData_o,
  output logic                            memRdValid_o,
  output logic [dcachePkg::AddrWidth-1:0] memRdAddr_o,
  input  logic                            memRdReady_i,
  input  logic [dcachePkg::Xlen-1:0]      memRdData_i,
  input  logic                            memRdDataValid_i,
  input  logic                            memRdLast_i,
  output logic                            memWrValid_o,
  output logic [dcachePkg::AddrWidth-1:0] memWrAddr_o,
  output dcachePkg::lineT                 memWrData_o,
  output logic [7:0]                      memWrLen_o,
  input  logic                            memWrReady_i
);
  import dcachePkg::*;

  cacheStateT          state;
  cacheAddrT           reqAddr;
  logic                reqWrite;
  logic                lineWrite;
  logic                wordWrite;
  logic                capture;
  logic                wrWay;
  logic                hit;
  logic                hitWay;
  logic                victimWay;
  logic                victimDirty;
  logic [TagWidth-1:0] victimTag;
  lineT                way0Line;
  lineT                way1Line;
  lineT                hitLine;
  lineT                victimLine;
  lineT                refillLine;
  lineT                uncachedLine;
  logic [Xlen-1:0]     wrDataQ;
  logic [Xlen/8-1:0]   wrMaskQ;

  // store payload held until the request completes
  always_ff @(posedge clk) begin
    if (reqValid_i && addrOk_o) begin
      wrDataQ <= wrData_i;
      wrMaskQ <= wrMask_i;
    end
  end

  dcacheCtrl i_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .reqValid_i       (reqValid_i),
    .reqWrite_i       (reqWrite_i),
    .reqAddr_i        (reqAddr_i),
    .hit_i            (hit),
    .victimDirty_i    (victimDirty),
    .memRdReady_i     (memRdReady_i),
    .memRdDataValid_i (memRdDataValid_i),
    .memRdLast_i      (memRdLast_i),
    .memWrReady_i     (memWrReady_i),
    .state_o          (state),
    .reqAddr_o        (reqAddr),
    .reqWrite_o       (reqWrite),
    .addrOk_o         (addrOk_o),
    .dataOk_o         (dataOk_o),
    .memRdValid_o     (memRdValid_o),
    .memWrValid_o     (memWrValid_o),
    .lineWrite_o      (lineWrite),
    .wordWrite_o      (wordWrite)
  );

  tagStore i_tags (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqAddr_i     (reqAddr),
    .state_i       (state),
    .wordWrite_i   (wordWrite),
    .lineWrite_i   (lineWrite),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  // store hits go to the hit way, refills to the victim
  assign wrWay = (state == COMPARE) ? hitWay : victimWay;

  lineStore i_lines (
    .clk          (clk),
    .reqAddr_i    (reqAddr),
    .lineWrite_i  (lineWrite),
    .wordWrite_i  (wordWrite),
    .wrWay_i      (wrWay),
    .refillLine_i (refillLine),
    .wrData_i     (wrDataQ),
    .wrMask_i     (wrMaskQ),
    .way0Line_o   (way0Line),
    .way1Line_o   (way1Line)
  );

  assign capture = state == REFILL;

  refillBuffer i_refill (
    .clk         (clk),
    .rst_n       (rst_n),
    .capture_i   (capture),
    .beatValid_i (memRdDataValid_i),
    .beatData_i  (memRdData_i),
    .line_o      (refillLine)
  );

  assign hitLine    = hitWay ? way1Line : way0Line;
  assign victimLine = victimWay ? way1Line : way0Line;

  // loads return the addressed word, stores return zero
  assign rdData_o = reqWrite ? '0 : hitLine.words[reqAddr.offset[OffsetWidth-1:3]];

  assign memRdAddr_o = {reqAddr.tag, reqAddr.index, {OffsetWidth{1'b0}}};

  // uncached word sits in the lowest slot of the line
  always_comb begin
    uncachedLine          = '0;
    uncachedLine.words[0] = wrDataQ;
  end

  always_comb begin
    if (state == UNCACHED) begin
      memWrAddr_o = {reqAddr.tag, reqAddr.index, reqAddr.offset[OffsetWidth-1:3], 3'b000};
      memWrData_o = uncachedLine;
      memWrLen_o  = BurstLenWord;
    end else begin
      memWrAddr_o = {victimTag, reqAddr.index, {OffsetWidth{1'b0}}};
      memWrData_o = victimLine;
      memWrLen_o  = BurstLenLine;
    end
  end

endmodule

// ==== bench/memModel.sv ====
`timescale 1ns/1ps

module memModel (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            randDelay_i,
  input  logic            rdValid_i,
  input  logic [31:0]     rdAddr_i,
  output logic            rdReady_o,
  output logic [63:0]     rdData_o,
  output logic            rdDataValid_o,
  output logic            rdLast_o,
  input  logic            wrValid_i,
  input  logic [31:0]     wrAddr_i,
  input  dcachePkg::lineT wrData_i,
  input  logic [7:0]      wrLen_i,
  output logic            wrReady_o
);
  import dcachePkg::*;

  // sparse storage keyed by word address
  logic [63:0] mem [logic [28:0]];
  logic [31:0] rdAddrQ [$];
  time         rdTimeQ [$];
  logic [31:0] wrAddrQ [$];
  logic [7:0]  wrLenQ [$];
  lineT        wrDataQ [$];
  time         wrTimeQ [$];
  logic [31:0] seed = 32'd13111;
  logic [28:0] burstWord;
  logic [1:0]  beat;
  logic        bursting;
  logic        rdArmed;
  logic        wrArmed;
  int          rdWait;
  int          wrWait;

  function automatic logic [63:0] fillWord(input logic [28:0] wa);
    return {~wa, 3'b110, {3'b000, wa} * 32'h9E3779B1};
  endfunction

  function automatic logic [63:0] readWord(input logic [28:0] wa);
    if (mem.exists(wa)) begin
      return mem[wa];
    end
    return fillWord(wa);
  endfunction

  // lcg step whose two state bits pick a delay of 0 to 3
  function automatic int nextDelay();
    seed = seed * 32'd1103515245 + 32'd12345;
    return randDelay_i ? int'(seed[17:16]) : 0;
  endfunction

  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdReady_o     = 1'b0;
      rdDataValid_o = 1'b0;
      rdLast_o      = 1'b0;
      rdData_o      = '0;
      wrReady_o     = 1'b0;
      bursting      = 1'b0;
      rdArmed       = 1'b0;
      wrArmed       = 1'b0;
      beat          = 2'd0;
    end else begin
      rdDataValid_o = 1'b0;
      rdLast_o      = 1'b0;
      // ready was taken at the last edge so the burst starts
      if (rdReady_o) begin
        rdReady_o = 1'b0;
        bursting  = 1'b1;
        beat      = 2'd0;
      end else if (rdValid_i && !bursting) begin
        if (!rdArmed) begin
          rdWait  = nextDelay();
          rdArmed = 1'b1;
        end
        if (rdWait == 0) begin
          rdReady_o = 1'b1;
          rdArmed   = 1'b0;
        end else begin
          rdWait = rdWait - 1;
        end
      end
      if (bursting) begin
        rdData_o      = readWord({burstWord[28:2], beat});
        rdDataValid_o = 1'b1;
        rdLast_o      = beat == 2'd3;
        if (beat == 2'd3) begin
          bursting = 1'b0;
        end
        beat = beat + 2'd1;
      end
      if (wrReady_o) begin
        wrReady_o = 1'b0;
      end else if (wrValid_i) begin
        if (!wrArmed) begin
          wrWait  = nextDelay();
          wrArmed = 1'b1;
        end
        if (wrWait == 0) begin
          wrReady_o = 1'b1;
          wrArmed   = 1'b0;
        end else begin
          wrWait = wrWait - 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (rdValid_i && rdReady_o) begin
      rdAddrQ.push_back(rdAddr_i);
      rdTimeQ.push_back($time);
      burstWord <= rdAddr_i[31:3];
    end
    if (wrValid_i && wrReady_o) begin
      wrAddrQ.push_back(wrAddr_i);
      wrLenQ.push_back(wrLen_i);
      wrDataQ.push_back(wrData_i);
      wrTimeQ.push_back($time);
      if (wrLen_i == 8'd0) begin
        mem[wrAddr_i[31:3]] = wrData_i.words[0];
      end else begin
        for (int k = 0; k < 4; k++) begin
          mem[{wrAddr_i[31:5], 2'(k)}] = wrData_i.words[k];
        end
      end
    end
  end

endmodule

// ==== bench/dcacheTb.sv ====
`timescale 1ns/1ps

module dcacheTb;
  import dcachePkg::*;

  // worst miss is writeback, refill and compare with slow memory
  localparam int TestAccesses  = 25;
  localparam int MaxMissCycles = 24;
  localparam int CycleLimit    = TestAccesses * MaxMissCycles + 200;

  logic                 clk;
  logic                 rst_n;
  logic                 reqValid;
  logic                 reqWrite;
  logic [AddrWidth-1:0] reqAddr;
  logic [Xlen-1:0]      wrData;
  logic [Xlen/8-1:0]    wrMask;
  logic                 addrOk;
  logic                 dataOk;
  logic [Xlen-1:0]      rdData;
  logic                 memRdValid;
  logic [AddrWidth-1:0] memRdAddr;
  logic                 memRdReady;
  logic [Xlen-1:0]      memRdData;
  logic                 memRdDataValid;
  logic                 memRdLast;
  logic                 memWrValid;
  logic [AddrWidth-1:0] memWrAddr;
  lineT                 memWrData;
  logic [7:0]           memWrLen;
  logic                 memWrReady;
  logic                 randDelay;
  int                   checks;
  int                   errors;
  int                   cycleCnt;

  // scoreboard of the sets and of memory contents
  logic [TagWidth-1:0]  tagM [Ways][Sets];
  logic                 validM [Ways][Sets];
  logic                 dirtyM [Ways][Sets];
  logic                 ptrM;
  logic [Xlen-1:0]      shadow [logic [28:0]];

  dcache i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .reqValid_i       (reqValid),
    .reqWrite_i       (reqWrite),
    .reqAddr_i        (reqAddr),
    .wrData_i         (wrData),
    .wrMask_i         (wrMask),
    .addrOk_o         (addrOk),
    .dataOk_o         (dataOk),
    .rdData_o         (rdData),
    .memRdValid_o     (memRdValid),
    .memRdAddr_o      (memRdAddr),
    .memRdReady_i     (memRdReady),
    .memRdData_i      (memRdData),
    .memRdDataValid_i (memRdDataValid),
    .memRdLast_i      (memRdLast),
    .memWrValid_o     (memWrValid),
    .memWrAddr_o      (memWrAddr),
    .memWrData_o      (memWrData),
    .memWrLen_o       (memWrLen),
    .memWrReady_i     (memWrReady)
  );

  memModel i_mem (
    .clk           (clk),
    .rst_n         (rst_n),
    .randDelay_i   (randDelay),
    .rdValid_i     (memRdValid),
    .rdAddr_i      (memRdAddr),
    .rdReady_o     (memRdReady),
    .rdData_o      (memRdData),
    .rdDataValid_o (memRdDataValid),
    .rdLast_o      (memRdLast),
    .wrValid_i     (memWrValid),
    .wrAddr_i      (memWrAddr),
    .wrData_i      (memWrData),
    .wrLen_i       (memWrLen),
    .wrReady_o     (memWrReady)
  );

  always #2 clk = ~clk;

  function automatic logic [63:0] fillWord(input logic [28:0] wa);
    return {~wa, 3'b110, {3'b000, wa} * 32'h9E3779B1};
  endfunction

  function automatic logic [63:0] shadowWord(input logic [28:0] wa);
    if (shadow.exists(wa)) begin
      return shadow[wa];
    end
    return fillWord(wa);
  endfunction

  task automatic checkWord(input string what, input logic [Xlen-1:0] got,
                           input logic [Xlen-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkLine(input string what, input lineT got, input lineT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkAddr(input string what, input cacheAddrT got, input cacheAddrT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic resetDut();
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int w = 0; w < Ways; w++) begin
      for (int s = 0; s < Sets; s++) begin
        validM[w][s] = 1'b0;
        dirtyM[w][s] = 1'b0;
      end
    end
    ptrM = 1'b0;
  endtask

  // one core request predicted from the scoreboard and checked at completion
  task automatic access(input logic wr, input logic [31:0] addr,
                        input logic [Xlen-1:0] data, input logic [7:0] mask);
    cacheAddrT        a;
    logic [5:0]       idx;
    logic             way;
    logic             hitM;
    int               expWr;
    int               expRd;
    cacheAddrT        expWrAddr;
    lineT             expLine;
    logic [7:0]       expLen;
    logic [Xlen-1:0]  w;
    int               wr0;
    int               rd0;
    int               cycles;
    a      = addr;
    idx    = a.index;
    expWr  = 0;
    expRd  = 0;
    hitM   = 1'b0;
    way    = 1'b0;
    expLen = 8'd3;
    expLine = '0;
    expWrAddr = '0;
    if (wr && addr[31:28] != 4'b1000) begin
      expWr             = 1;
      expWrAddr         = {addr[31:3], 3'b000};
      expLine.words[0]  = data;
      expLen            = 8'd0;
      shadow[addr[31:3]] = data;
    end else begin
      for (int k = 0; k < Ways; k++) begin
        if (validM[k][idx] && tagM[k][idx] == a.tag) begin
          hitM = 1'b1;
          way  = k[0];
        end
      end
      if (!hitM) begin
        way  = ptrM;
        ptrM = ~ptrM;
        expRd = 1;
        if (validM[way][idx] && dirtyM[way][idx]) begin
          expWr     = 1;
          expWrAddr = {tagM[way][idx], idx, 5'b00000};
          for (int k = 0; k < LineWords; k++) begin
            expLine.words[k] = shadowWord({tagM[way][idx], idx, 2'(k)});
          end
        end
        tagM[way][idx]   = a.tag;
        validM[way][idx] = 1'b1;
        dirtyM[way][idx] = 1'b0;
      end
      if (wr) begin
        w = shadowWord(addr[31:3]);
        for (int b = 0; b < 8; b++) begin
          if (mask[b]) begin
            w[b*8 +: 8] = data[b*8 +: 8];
          end
        end
        shadow[addr[31:3]] = w;
        dirtyM[way][idx]   = 1'b1;
      end
    end
    wr0 = i_mem.wrAddrQ.size();
    rd0 = i_mem.rdAddrQ.size();
    @(negedge clk);
    #1;
    checkWord("addrOk before request", 64'(addrOk), 64'd1);
    @(negedge clk);
    reqValid = 1'b1;
    reqWrite = wr;
    reqAddr  = addr;
    wrData   = data;
    wrMask   = mask;
    @(negedge clk);
    reqValid = 1'b0;
    #1;
    cycles = 1;
    while (!dataOk) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (hitM) begin
      checkWord("hit latency", 64'(cycles), 64'd1);
    end
    if (!wr) begin
      checkWord("load data", rdData, shadowWord(addr[31:3]));
    end else if (expLen == 8'd0) begin
      checkWord("write accepted with dataOk", 64'(memWrReady), 64'd1);
    end
    // let the memory record the last accepted write
    @(posedge clk);
    #1;
    checkWord("memory writes", 64'(i_mem.wrAddrQ.size() - wr0), 64'(expWr));
    checkWord("memory reads", 64'(i_mem.rdAddrQ.size() - rd0), 64'(expRd));
    if (expWr == 1 && i_mem.wrAddrQ.size() > wr0) begin
      checkAddr("write address", i_mem.wrAddrQ[wr0], expWrAddr);
      checkWord("write length", 64'(i_mem.wrLenQ[wr0]), 64'(expLen));
      checkLine("write data", i_mem.wrDataQ[wr0], expLine);
    end
    if (expRd == 1 && i_mem.rdAddrQ.size() > rd0) begin
      checkAddr("refill address", i_mem.rdAddrQ[rd0], {addr[31:5], 5'b00000});
      if (expWr == 1 && i_mem.wrAddrQ.size() > wr0) begin
        checkWord("writeback before refill",
                  64'(i_mem.wrTimeQ[wr0] < i_mem.rdTimeQ[rd0]), 64'd1);
      end
    end
  endtask

  task automatic reportTest(input string name, input int startErr);
    $display("test %s finished with %0d errors", name, errors - startErr);
  endtask

  task automatic firstLoadTest();
    int e0;
    e0 = errors;
    #1;
    checkWord("addrOk after reset", 64'(addrOk), 64'd1);
    checkWord("dataOk after reset", 64'(dataOk), 64'd0);
    checkWord("memRdValid after reset", 64'(memRdValid), 64'd0);
    checkWord("memWrValid after reset", 64'(memWrValid), 64'd0);
    access(1'b0, 32'h8000_0048, '0, '0);
    access(1'b0, 32'h8000_0048, '0, '0);
    reportTest("first load", e0);
  endtask

  task automatic storeHitTest();
    int e0;
    e0 = errors;
    access(1'b1, 32'h8000_0058, 64'h1122_3344_5566_7788, 8'b0011_0110);
    access(1'b0, 32'h8000_0058, '0, '0);
    reportTest("store hit", e0);
  endtask

  task automatic conflictTest();
    int e0;
    e0 = errors;
    access(1'b0, 32'h8000_00A0, '0, '0);
    access(1'b0, 32'h8000_08A0, '0, '0);
    access(1'b0, 32'h8000_10A0, '0, '0);
    // survivor of the toggling eviction
    access(1'b0, 32'h8000_08A0, '0, '0);
    reportTest("set conflict", e0);
  endtask

  task automatic dirtyEvictTest();
    int e0;
    int w0;
    e0 = errors;
    w0 = i_mem.wrAddrQ.size();
    access(1'b1, 32'h8000_0128, 64'hDEAD_BEEF_0BAD_F00D, 8'b1100_0011);
    access(1'b0, 32'h8000_0928, '0, '0);
    access(1'b0, 32'h8000_1128, '0, '0);
    access(1'b0, 32'h8000_0128, '0, '0);
    checkWord("writebacks in test", 64'(i_mem.wrAddrQ.size() - w0), 64'd1);
    reportTest("dirty eviction", e0);
  endtask

  task automatic uncachedStoreTest();
    int e0;
    e0 = errors;
    access(1'b1, 32'h4000_0014, 64'hCAFE_F00D_1234_5678, 8'hFF);
    reportTest("uncached store", e0);
  endtask

  initial begin
    cycleCnt = 0;
    while (cycleCnt < CycleLimit) begin
      @(posedge clk);
      cycleCnt++;
    end
    $display("timeout: run did not finish within %0d cycles", CycleLimit);
    $display("Checks failed");
    $finish;
  end

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    reqValid  = 1'b0;
    reqWrite  = 1'b0;
    reqAddr   = '0;
    wrData    = '0;
    wrMask    = '0;
    randDelay = 1'b0;
    checks    = 0;
    errors    = 0;
    resetDut();
    firstLoadTest();
    storeHitTest();
    conflictTest();
    dirtyEvictTest();
    uncachedStoreTest();
    // same sequence against a slow memory
    randDelay = 1'b1;
    resetDut();
    firstLoadTest();
    storeHitTest();
    conflictTest();
    dirtyEvictTest();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
rtl/dcachePkg.sv
rtl/refillBuffer.sv
rtl/lineStore.sv
rtl/tagStore.sv
rtl/dcacheCtrl.sv
rtl/dcache.sv
bench/memModel.sv
bench/dcacheTb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = dcacheTb
RTLTOP    = dcache
FILELIST  = project.f

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(RTLTOP) rtl/dcachePkg.sv rtl/refillBuffer.sv \
		rtl/lineStore.sv rtl/tagStore.sv rtl/dcacheCtrl.sv rtl/dcache.sv

clean:
	rm -rf obj_dir
